// File: logic/gmii_rx_macros.svh
`ifndef GMII_RX_MACROS_SVH
`define GMII_RX_MACROS_SVH

// byte offsets from the first rx_dv byte, preamble and sfd included
`define OFS_ETYPE    11'd20  // 2 bytes
`define OFS_IPVER    11'd22
`define OFS_PROTO    11'd31
`define OFS_IPDST    11'd38  // 4 bytes
`define OFS_UDPDST   11'd44  // 2 bytes
`define OFS_PAYLOAD  11'd50

// expected header values
`define ETYPE_IPV4   16'h0800
`define IPVER_V4     8'h45   // v4, no options
`define PROTO_UDP    8'h11

// node address 192.168.0.1, id input adds to it
`define NODE_IP      32'hc0a8_0001
`define PORT_VIDEO   16'd12345
`define PORT_AUX     16'd12346

// last byte index taken from each payload kind
`define VIDEO_LAST   11'd1330
`define AUX_LAST     11'd114

// receiver credits, initial and max
`define RX_CREDITS   4'd8

`endif

// File: logic/net_pkg.sv
package net_pkg;

	// one gmii byte
	typedef logic [7:0] byte_t;

	// position in the frame, counted from the first rx_dv byte
	typedef logic [10:0] byte_idx_t;

	typedef logic [15:0] etype_t;
	typedef logic [31:0] ipv4_addr_t;
	typedef logic [15:0] udp_port_t;

	// what the payload of the current frame is
	typedef enum logic [1:0] {
		FC_NONE  = 2'd0,
		FC_VIDEO = 2'd1,
		FC_AUX   = 2'd2
	} frame_class_t;

endpackage

// File: logic/media_pkg.sv
package media_pkg;

	typedef logic [10:0] line_t;    // low bits of the 12-bit line number
	typedef logic [11:0] sample_t;  // packed audio sample

	// one pixel pair with the line header of its frame
	typedef struct packed {
		logic           field;
		line_t          line;
		net_pkg::byte_t px0;  // first byte of the pair
		net_pkg::byte_t px1;
	} video_word_t;

	// tagged output word
	// kind 0 carries a video_word_t
	// kind 1 carries a sample in the low 12 bits
	typedef struct packed {
		logic        kind;
		logic [27:0] payload;
	} media_word_t;

endpackage

// File: logic/udp_hdr_filter.sv
`include "gmii_rx_macros.svh"

module udp_hdr_filter (
	input  logic                  clk125,
	input  logic                  sys_rst,
	input  net_pkg::byte_t        rxd,
	input  logic                  rx_dv,
	input  logic                  id,
	output net_pkg::byte_t        pay_byte,
	output logic                  pay_dv,
	output net_pkg::byte_idx_t    byte_idx,
	output net_pkg::frame_class_t frame_class
);

	net_pkg::byte_idx_t  rx_count;  // index of the byte on rxd now
	net_pkg::etype_t     eth_type;
	net_pkg::byte_t      ip_ver;
	net_pkg::byte_t      ip_proto;
	net_pkg::ipv4_addr_t ip_dst;
	net_pkg::udp_port_t  udp_dst;

	net_pkg::ipv4_addr_t node_dst;
	logic                hdr_ok;

	// id moves the accepted address up by one
	assign node_dst = `NODE_IP + {31'd0, id};

	assign hdr_ok = (eth_type == `ETYPE_IPV4) &&
		(ip_ver == `IPVER_V4) &&
		(ip_proto == `PROTO_UDP) &&
		(ip_dst == node_dst);

	// byte counting, header capture and class decision
	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			rx_count    <= '0;
			eth_type    <= '0;
			ip_ver      <= '0;
			ip_proto    <= '0;
			ip_dst      <= '0;
			udp_dst     <= '0;
			frame_class <= net_pkg::FC_NONE;
		end else if (rx_dv) begin
			if (rx_count != 11'h7ff)
				rx_count <= rx_count + 11'd1;  // hold at the top on giant frames
			case (rx_count)
				`OFS_ETYPE:              eth_type[15:8] <= rxd;
				`OFS_ETYPE + 11'd1:      eth_type[7:0]  <= rxd;
				`OFS_IPVER:              ip_ver         <= rxd;
				`OFS_PROTO:              ip_proto       <= rxd;
				`OFS_IPDST:              ip_dst[31:24]  <= rxd;
				`OFS_IPDST + 11'd1:      ip_dst[23:16]  <= rxd;
				`OFS_IPDST + 11'd2:      ip_dst[15:8]   <= rxd;
				`OFS_IPDST + 11'd3:      ip_dst[7:0]    <= rxd;
				`OFS_UDPDST:             udp_dst[15:8]  <= rxd;
				`OFS_UDPDST + 11'd1:     udp_dst[7:0]   <= rxd;
				`OFS_PAYLOAD: begin
					// all header bytes are in by now
					if (hdr_ok && udp_dst == `PORT_VIDEO)
						frame_class <= net_pkg::FC_VIDEO;
					else if (hdr_ok && udp_dst == `PORT_AUX)
						frame_class <= net_pkg::FC_AUX;
					else
						frame_class <= net_pkg::FC_NONE;
				end
				default: ;
			endcase
		end else begin
			// end of frame, forget everything
			rx_count    <= '0;
			eth_type    <= '0;
			ip_ver      <= '0;
			ip_proto    <= '0;
			ip_dst      <= '0;
			udp_dst     <= '0;
			frame_class <= net_pkg::FC_NONE;
		end
	end

	// byte stream to the unpackers, one cycle behind rxd
	always_ff @(posedge clk125) begin
		if (sys_rst)
			pay_dv <= 1'b0;
		else
			pay_dv <= rx_dv;
	end

	always_ff @(posedge clk125) begin
		pay_byte <= rxd;
		byte_idx <= rx_count;
	end

endmodule

// File: logic/video_unpack.sv
`include "gmii_rx_macros.svh"

module video_unpack (
	input  logic                     clk125,
	input  logic                     sys_rst,
	input  net_pkg::byte_t           pay_byte,
	input  logic                     pay_dv,
	input  net_pkg::byte_idx_t       byte_idx,
	input  net_pkg::frame_class_t    frame_class,
	output logic                     vid_valid,
	output media_pkg::video_word_t   vid_word
);

	typedef enum logic {
		PIX_FIRST,
		PIX_SECOND
	} pix_state_t;

	pix_state_t        state;
	media_pkg::line_t  line_num;
	logic              field_bit;
	net_pkg::byte_t    first_px;   // waits for its partner
	logic              vid_byte;
	logic              pix_byte;

	assign vid_byte = pay_dv && (frame_class == net_pkg::FC_VIDEO);
	// pixel data starts after the two header bytes
	assign pix_byte = vid_byte && (byte_idx > `OFS_PAYLOAD + 11'd1) &&
		(byte_idx <= `VIDEO_LAST);

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			state     <= PIX_FIRST;
			vid_valid <= 1'b0;
		end else begin
			vid_valid <= 1'b0;
			if (frame_class != net_pkg::FC_VIDEO) begin
				state <= PIX_FIRST;  // drops an unpaired byte
			end else if (pix_byte) begin
				state     <= (state == PIX_FIRST) ? PIX_SECOND : PIX_FIRST;
				vid_valid <= (state == PIX_SECOND);
			end
		end
	end

	always_ff @(posedge clk125) begin
		if (vid_byte && byte_idx == `OFS_PAYLOAD)
			line_num[7:0] <= pay_byte;
		if (vid_byte && byte_idx == `OFS_PAYLOAD + 11'd1) begin
			line_num[10:8] <= pay_byte[2:0];  // bit 11 of the line is not kept
			field_bit      <= pay_byte[4];
		end
		if (pix_byte && state == PIX_FIRST)
			first_px <= pay_byte;
		if (pix_byte && state == PIX_SECOND)
			vid_word <= '{field: field_bit, line: line_num, px0: first_px, px1: pay_byte};
	end

endmodule

// File: logic/aux_unpack.sv
`include "gmii_rx_macros.svh"

module aux_unpack (
	input  logic                  clk125,
	input  logic                  sys_rst,
	input  net_pkg::byte_t        pay_byte,
	input  logic                  pay_dv,
	input  net_pkg::byte_idx_t    byte_idx,
	input  net_pkg::frame_class_t frame_class,
	output logic                  aux_valid,
	output media_pkg::sample_t    aux_word
);

	typedef enum logic [1:0] {
		GRP_B0,
		GRP_B1,
		GRP_B2
	} grp_state_t;

	grp_state_t     state;
	net_pkg::byte_t lo_byte;    // b0, low 8 bits of sample one
	logic [3:0]     spare_nib;  // b1 high nibble, low bits of sample two
	logic           aux_byte;

	assign aux_byte = pay_dv && (frame_class == net_pkg::FC_AUX) &&
		(byte_idx <= `AUX_LAST);

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			state     <= GRP_B0;
			aux_valid <= 1'b0;
		end else begin
			aux_valid <= 1'b0;
			if (frame_class != net_pkg::FC_AUX) begin
				state <= GRP_B0;
			end else if (aux_byte) begin
				case (state)
					GRP_B0: state <= GRP_B1;
					GRP_B1: begin
						state     <= GRP_B2;
						aux_valid <= 1'b1;
					end
					default: begin
						state     <= GRP_B0;
						aux_valid <= 1'b1;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk125) begin
		if (aux_byte && state == GRP_B0)
			lo_byte <= pay_byte;
		if (aux_byte && state == GRP_B1) begin
			aux_word  <= {pay_byte[3:0], lo_byte};
			spare_nib <= pay_byte[7:4];
		end
		if (aux_byte && state == GRP_B2)
			aux_word <= {pay_byte, spare_nib};
	end

endmodule

// File: logic/media_merge.sv
`include "gmii_rx_macros.svh"

module media_merge (
	input  logic                   clk125,
	input  logic                   sys_rst,
	input  logic                   vid_valid,
	input  media_pkg::video_word_t vid_word,
	input  logic                   aux_valid,
	input  media_pkg::sample_t     aux_word,
	input  logic                   credit_return,
	output logic                   out_valid,
	output media_pkg::media_word_t out_word,
	output logic [15:0]            drop_count
);

	media_pkg::media_word_t in_word;
	logic                   in_valid;
	logic                   send;
	logic [3:0]             credits;

	assign in_valid = vid_valid || aux_valid;
	assign send     = in_valid && (credits != 4'd0);

	always_comb begin
		in_word.kind = aux_valid;
		if (aux_valid)
			in_word.payload = {16'd0, aux_word};
		else
			in_word.payload = vid_word;
	end

	always_ff @(posedge clk125) begin
		if (sys_rst) begin
			out_valid  <= 1'b0;
			credits    <= `RX_CREDITS;
			drop_count <= '0;
		end else begin
			out_valid <= send;
			if (in_valid && !send)
				drop_count <= drop_count + 16'd1;  // no credit, word is lost
			if (send && !credit_return)
				credits <= credits - 4'd1;
			else if (credit_return && !send)
				credits <= credits + 4'd1;
		end
	end

	always_ff @(posedge clk125) begin
		if (send)
			out_word <= in_word;
	end

	// one frame has one class, so the unpackers never collide
	a_one_source: assert property (@(posedge clk125) disable iff (sys_rst)
		!(vid_valid && aux_valid));

	// receiver returned more than it was given
	a_credit_max: assert property (@(posedge clk125) disable iff (sys_rst)
		credit_return |-> (send || credits < `RX_CREDITS));

endmodule

// File: logic/gmii_media_rx.sv
`include "gmii_rx_macros.svh"

// a word leaves three clocks after its last byte is sampled on rxd
module gmii_media_rx (
	input  logic                   clk125,
	input  logic                   sys_rst,
	input  net_pkg::byte_t         rxd,
	input  logic                   rx_dv,
	input  logic                   id,
	input  logic                   credit_return,
	output logic                   out_valid,
	output media_pkg::media_word_t out_word,
	output logic [15:0]            drop_count
);

	net_pkg::byte_t         pay_byte;
	logic                   pay_dv;
	net_pkg::byte_idx_t     byte_idx;
	net_pkg::frame_class_t  frame_class;
	logic                   vid_valid;
	media_pkg::video_word_t vid_word;
	logic                   aux_valid;
	media_pkg::sample_t     aux_word;

	udp_hdr_filter i_filter (
		.clk125, .sys_rst, .rxd, .rx_dv, .id,
		.pay_byte, .pay_dv, .byte_idx, .frame_class
	);

	video_unpack i_video (
		.clk125, .sys_rst, .pay_byte, .pay_dv, .byte_idx, .frame_class,
		.vid_valid, .vid_word
	);

	aux_unpack i_aux (
		.clk125, .sys_rst, .pay_byte, .pay_dv, .byte_idx, .frame_class,
		.aux_valid, .aux_word
	);

	media_merge i_merge (
		.clk125, .sys_rst, .vid_valid, .vid_word, .aux_valid, .aux_word,
		.credit_return, .out_valid, .out_word, .drop_count
	);

endmodule

// File: dv/media_rx_tb.sv
`include "gmii_rx_macros.svh"

module media_rx_tb;

	typedef struct packed {
		logic [7:0]  dst_lo;   // last byte of the ip destination
		logic        id;
		logic [15:0] port;
		logic [15:0] etype;
		logic [7:0]  proto;
		int          pay_len;  // bytes from the payload offset, fcs not counted
		logic        cut;      // rx_dv falls before the fcs
		logic        ret;      // receiver hands credits back
		int          words;    // words expected on the output
	} frame_spec_t;

	localparam int PAY_OFS = int'(`OFS_PAYLOAD);
	localparam int VID_LAST = int'(`VIDEO_LAST);
	localparam int AUX_LAST = int'(`AUX_LAST);
	localparam int CREDITS = int'(`RX_CREDITS);

	logic                   clk125 = 1'b0;
	logic                   sys_rst = 1'b1;
	logic [7:0]             rxd = 8'd0;
	logic                   rx_dv = 1'b0;
	logic                   id = 1'b0;
	logic                   credit_return = 1'b0;
	logic                   out_valid;
	media_pkg::media_word_t out_word;
	logic [15:0]            drop_count;

	frame_spec_t tbl[$];
	string       names[$];
	logic [7:0]  frame[$];
	logic [28:0] model_q[$];
	logic [28:0] exp_q[$];
	logic [28:0] exp_w;
	logic [31:0] lfsr = 32'h5eb4_6b93;
	int          errors = 0;
	int          got_words = 0;
	int          owed = 0;  // credits not yet handed back
	logic        ret_en = 1'b0;
	logic        hung = 1'b0;

	gmii_media_rx i_dut (
		.clk125, .sys_rst, .rxd, .rx_dv, .id, .credit_return,
		.out_valid, .out_word, .drop_count
	);

	always #50 clk125 = ~clk125;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = 8'd0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic add_frame(input string nm, input logic [7:0] dst_lo, input logic idv,
		input logic [15:0] port, input logic [15:0] etype, input logic [7:0] proto,
		input int len, input logic cut, input logic ret, input int words);
		frame_spec_t s;
		s = '{dst_lo, idv, port, etype, proto, len, cut, ret, words};
		names.push_back(nm);
		tbl.push_back(s);
	endtask

	// preamble, random header bytes, then the checked fields on top
	task automatic build_frame(input frame_spec_t s);
		logic [7:0] b;
		frame.delete();
		for (int i = 0; i < 7; i++)
			frame.push_back(8'h55);
		frame.push_back(8'hd5);
		for (int i = 8; i < PAY_OFS + s.pay_len + (s.cut ? 0 : 4); i++) begin
			rand_byte(b);
			frame.push_back(b);
		end
		frame[20] = s.etype[15:8];
		frame[21] = s.etype[7:0];
		frame[22] = `IPVER_V4;
		frame[31] = s.proto;
		frame[38] = 8'hc0;  // 192.168.0.x
		frame[39] = 8'ha8;
		frame[40] = 8'h00;
		frame[41] = s.dst_lo;
		frame[44] = s.port[15:8];
		frame[45] = s.port[7:0];
	endtask

	task automatic run_model(input frame_spec_t s);
		logic        hit;
		logic [10:0] line;
		int          last;
		hit = (s.etype == `ETYPE_IPV4) && (s.proto == `PROTO_UDP) &&
			(s.dst_lo == 8'h01 + {7'd0, s.id});
		model_q.delete();
		last = frame.size() - 1;
		if (hit && s.port == `PORT_VIDEO && last > PAY_OFS + 1) begin
			line = {frame[PAY_OFS + 1][2:0], frame[PAY_OFS]};  // line bit 11 is dropped
			if (last > VID_LAST)
				last = VID_LAST;
			for (int i = PAY_OFS + 2; i + 1 <= last; i += 2)
				model_q.push_back({1'b0, frame[PAY_OFS + 1][4], line, frame[i], frame[i + 1]});
		end
		if (hit && s.port == `PORT_AUX) begin
			if (last > AUX_LAST)
				last = AUX_LAST;
			for (int i = PAY_OFS + 1; i <= last; i++) begin
				if ((i - PAY_OFS) % 3 == 1)
					model_q.push_back({1'b1, 16'd0, frame[i][3:0], frame[i - 1]});
				else if ((i - PAY_OFS) % 3 == 2)
					model_q.push_back({1'b1, 16'd0, frame[i], frame[i - 1][7:4]});
			end
		end
	endtask

	task automatic send_frame();
		foreach (frame[i]) begin
			rxd   <= frame[i];
			rx_dv <= 1'b1;
			@(posedge clk125);
		end
		rxd   <= 8'd0;
		rx_dv <= 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 2000) begin
			@(posedge clk125);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d expected words never came out", exp_q.size());
			hung = 1'b1;
		end
	endtask

	task automatic wait_credits();
		int n;
		n = 0;
		while (owed != 0 && n < 100) begin
			@(posedge clk125);
			n++;
		end
		if (owed != 0) begin
			$display("timeout: %0d credits were never handed back", owed);
			hung = 1'b1;
		end
	endtask

	// output monitor
	always @(posedge clk125) begin
		if (!sys_rst && out_valid) begin
			got_words++;
			if (exp_q.size() == 0) begin
				$display("unexpected word %h on the output at time %0t", out_word, $time);
				errors++;
			end else begin
				exp_w = exp_q.pop_front();
				check("out_word", {3'd0, out_word}, {3'd0, exp_w});
			end
		end
	end

	// receiver, one credit back per word while returns are on
	always @(posedge clk125) begin
		if (sys_rst) begin
			credit_return <= 1'b0;
			owed = 0;
		end else begin
			if (out_valid)
				owed = owed + 1;
			if (ret_en && owed > 0) begin
				credit_return <= 1'b1;
				owed = owed - 1;
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	initial begin
		frame_spec_t s;
		string       res;
		int          drops0;
		int          got0;
		int          err0;
		int          exp_drops;
		int          ran;
		ran = 0;
		//        name            dst    id    port         etype     proto  len  cut   ret   words
		add_frame("vid_basic",    8'h01, 1'b0, `PORT_VIDEO, 16'h0800, 8'h11, 40,  1'b0, 1'b1, 21);
		add_frame("aux_basic",    8'h01, 1'b0, `PORT_AUX,   16'h0800, 8'h11, 29,  1'b0, 1'b1, 22);
		add_frame("aux_long",     8'h01, 1'b0, `PORT_AUX,   16'h0800, 8'h11, 100, 1'b0, 1'b1, 43);
		add_frame("bad_etype",    8'h01, 1'b0, `PORT_VIDEO, 16'h86dd, 8'h11, 40,  1'b0, 1'b1, 0);
		add_frame("bad_proto",    8'h01, 1'b0, `PORT_VIDEO, 16'h0800, 8'h06, 40,  1'b0, 1'b1, 0);
		add_frame("bad_dst",      8'h07, 1'b0, `PORT_VIDEO, 16'h0800, 8'h11, 40,  1'b0, 1'b1, 0);
		add_frame("bad_port",     8'h01, 1'b0, 16'd80,      16'h0800, 8'h11, 40,  1'b0, 1'b1, 0);
		add_frame("id_miss",      8'h01, 1'b1, `PORT_VIDEO, 16'h0800, 8'h11, 40,  1'b0, 1'b1, 0);
		add_frame("id_hit",       8'h02, 1'b1, `PORT_AUX,   16'h0800, 8'h11, 8,   1'b0, 1'b1, 8);
		add_frame("vid_long",     8'h01, 1'b0, `PORT_VIDEO, 16'h0800, 8'h11, 1300, 1'b0, 1'b1, 639);
		add_frame("vid_cut",      8'h01, 1'b0, `PORT_VIDEO, 16'h0800, 8'h11, 25,  1'b1, 1'b1, 11);
		add_frame("no_credit",    8'h01, 1'b0, `PORT_VIDEO, 16'h0800, 8'h11, 40,  1'b0, 1'b0, 8);
		add_frame("after_credit", 8'h01, 1'b0, `PORT_VIDEO, 16'h0800, 8'h11, 20,  1'b0, 1'b1, 11);

		repeat (8) @(posedge clk125);
		sys_rst <= 1'b0;
		repeat (2) @(posedge clk125);
		check("out_valid after reset", {31'd0, out_valid}, 32'd0);
		check("drop_count after reset", {16'd0, drop_count}, 32'd0);

		for (int t = 0; t < tbl.size(); t++) begin
			s = tbl[t];
			err0 = errors;
			build_frame(s);
			run_model(s);
			exp_drops = 0;
			if (!s.ret && model_q.size() > CREDITS)
				exp_drops = model_q.size() - CREDITS;  // credits start full
			while (model_q.size() > CREDITS && !s.ret)
				void'(model_q.pop_back());
			foreach (model_q[i])
				exp_q.push_back(model_q[i]);
			got0 = got_words;
			drops0 = int'(drop_count);
			id <= s.id;
			ret_en <= s.ret;
			@(posedge clk125);
			send_frame();
			wait_drain();
			if (hung)
				break;
			repeat (12) @(posedge clk125);  // gap, late words would show here
			if (s.ret)
				wait_credits();
			if (hung)
				break;
			check("drop_count", {16'd0, drop_count}, drops0 + exp_drops);
			check("words out", got_words - got0, s.words);
			ran++;
			if (errors == err0)
				res = "ok";
			else
				res = "FAILED";
			$display("test %-13s %s, %0d words, %0d drops", names[t], res,
				got_words - got0, exp_drops);
		end

		$display("tests run %0d of %0d, errors %0d", ran, tbl.size(), errors);
		if (errors == 0 && !hung)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: files.f
+incdir+logic
logic/net_pkg.sv
logic/media_pkg.sv
logic/udp_hdr_filter.sv
logic/video_unpack.sv
logic/aux_unpack.sv
logic/media_merge.sv
logic/gmii_media_rx.sv
dv/media_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module media_rx_tb -o media_rx_sim

out=$(./obj_dir/media_rx_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
